/* design/drum_pkg.sv */
`default_nettype none

package drum_pkg;

	// Node displacement in 1.17 fixed point
	typedef logic signed [17:0] node_t;

	// Audio sample word
	typedef logic [31:0] sample_t;

	localparam int SAMPLE_SHIFT = 14;
	localparam int ADDR_W = 9;

	// Upper bound on the tension term
	localparam node_t RHO_MAX = 18'h0FAE1;

	typedef struct packed {
		node_t init_node;
		node_t incr_col;
		node_t incr_row;
		node_t init_rho;
	} drum_config_t;

	typedef struct packed {
		node_t init_center;
		node_t incr;
	} column_seed_t;

	// 1.17 by 1.17 multiply, keeps sign and drops the redundant integer bit
	function automatic node_t fix_mul(input node_t a, input node_t b);
		logic signed [35:0] product;
		product = a * b;
		return {product[35], product[33:17]};
	endfunction

endpackage

`default_nettype wire

/* design/column_memory.sv */
`default_nettype none

module column_memory (
	input  logic                          clk,
	input  logic                          write_enable,
	input  logic [drum_pkg::ADDR_W-1:0]   write_address,
	input  logic [drum_pkg::ADDR_W-1:0]   read_address,
	input  drum_pkg::node_t               d,
	output drum_pkg::node_t               q
);

	drum_pkg::node_t mem [2**drum_pkg::ADDR_W];

	always_ff @(posedge clk) begin
		if (write_enable) begin
			mem[write_address] <= d;
		end
		q <= mem[read_address];
	end

endmodule

`default_nettype wire

/* design/node_update.sv */
`default_nettype none

module node_update #(
	parameter int ETA_SHIFT = 9
) (
	input  drum_pkg::node_t curr,
	input  drum_pkg::node_t left,
	input  drum_pkg::node_t right,
	input  drum_pkg::node_t top,
	input  drum_pkg::node_t bottom,
	input  drum_pkg::node_t prev,
	input  drum_pkg::node_t rho,
	output drum_pkg::node_t next
);

	drum_pkg::node_t laplace;
	drum_pkg::node_t tension_term;
	drum_pkg::node_t damped_prev;
	drum_pkg::node_t undamped;

	// Discrete Laplacian over the four neighbours
	assign laplace = left + right + top + bottom - (curr <<< 2);

	assign tension_term = drum_pkg::fix_mul(laplace, rho);

	// Previous step loses a little energy
	assign damped_prev = prev - (prev >>> ETA_SHIFT);

	assign undamped = tension_term + (curr <<< 1) - damped_prev;

	// Second damping pass on the new value
	assign next = undamped - (undamped >>> ETA_SHIFT);

endmodule

`default_nettype wire

/* design/drum_column.sv */
`default_nettype none

module drum_column #(
	parameter int NUM_ROWS  = 7,
	parameter int ETA_SHIFT = 9
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start,
	input  logic                    step,
	input  drum_pkg::column_seed_t  seed,
	input  drum_pkg::node_t         init_node,
	input  drum_pkg::node_t         rho,
	input  drum_pkg::node_t         left_node,
	input  drum_pkg::node_t         right_node,
	output drum_pkg::node_t         curr_node,
	output drum_pkg::node_t         centre,
	output logic                    done
);

	localparam int AW = drum_pkg::ADDR_W;
	localparam logic [AW-1:0] LAST_ROW   = AW'(NUM_ROWS - 1);
	localparam logic [AW-1:0] PENULT_ROW = AW'(NUM_ROWS - 2);
	localparam logic [AW-1:0] MID_ROW    = AW'(NUM_ROWS / 2);

	localparam logic [2:0] WAIT_START = 3'd0;
	localparam logic [2:0] LOAD       = 3'd1;
	localparam logic [2:0] BASE_1     = 3'd2;
	localparam logic [2:0] BASE_2     = 3'd3;
	localparam logic [2:0] IDLE       = 3'd4;
	localparam logic [2:0] CALC       = 3'd5;
	localparam logic [2:0] UPDATE     = 3'd6;

	logic [2:0]      state;
	logic [AW-1:0]   row;
	logic [AW-1:0]   curr_rd;
	logic [AW-1:0]   prev_rd;
	logic            mem_we;
	drum_pkg::node_t curr_d, prev_d, curr_q, prev_q;
	drum_pkg::node_t run, load_value;
	drum_pkg::node_t node_q, top_q, bottom_q, prev_node_q, centre_q;
	drum_pkg::node_t top_in, bottom_in, next_node;

	column_memory u_curr_mem (
		.clk           (clk),
		.write_enable  (mem_we),
		.write_address (row),
		.read_address  (curr_rd),
		.d             (curr_d),
		.q             (curr_q)
	);

	column_memory u_prev_mem (
		.clk           (clk),
		.write_enable  (mem_we),
		.write_address (row),
		.read_address  (prev_rd),
		.d             (prev_d),
		.q             (prev_q)
	);

	// Edge rows see a fixed rim
	assign top_in    = (row == LAST_ROW) ? '0 : top_q;
	assign bottom_in = (row == '0) ? '0 : bottom_q;

	node_update #(.ETA_SHIFT(ETA_SHIFT)) u_node_update (
		.curr   (node_q),
		.left   (left_node),
		.right  (right_node),
		.top    (top_in),
		.bottom (bottom_in),
		.prev   (prev_node_q),
		.rho    (rho),
		.next   (next_node)
	);

	// Rising then falling row profile, capped at the column peak
	assign load_value = (run < seed.init_center) ? run : seed.init_center;

	////////////////////
	// Memory port control
	////////////////////
	always_comb begin
		mem_we  = 1'b0;
		curr_d  = load_value;
		prev_d  = load_value;
		curr_rd = AW'(1);
		prev_rd = '0;
		case (state)
			LOAD: mem_we = 1'b1;
			BASE_1: curr_rd = '0;
			UPDATE: begin
				mem_we = 1'b1;
				curr_d = next_node;
				prev_d = node_q;
				prev_rd = row + 1'b1;
				curr_rd = row + 2'd2;
				// Wrap so row 0 and 1 are ready for the next sweep
				if (row == PENULT_ROW) begin
					curr_rd = '0;
				end else if (row == LAST_ROW) begin
					curr_rd = AW'(1);
					prev_rd = '0;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= WAIT_START;
			row <= '0;
		end else begin
			case (state)
				WAIT_START: if (start) state <= LOAD;
				LOAD: begin
					row <= row + 1'b1;
					if (row == LAST_ROW) state <= BASE_1;
				end
				BASE_1: state <= BASE_2;
				BASE_2: begin
					state <= IDLE;
					row <= '0;
				end
				IDLE: if (step) state <= CALC;
				CALC: state <= UPDATE;
				UPDATE: begin
					if (row == LAST_ROW) begin
						state <= IDLE;
						row <= '0;
					end else begin
						state <= CALC;
						row <= row + 1'b1;
					end
				end
				default: state <= WAIT_START;
			endcase
		end
	end

	////////////////////
	// Node pipeline
	////////////////////
	always_ff @(posedge clk) begin
		case (state)
			WAIT_START: run <= init_node;
			LOAD: begin
				run <= (row < MID_ROW) ? run + seed.incr : run - seed.incr;
				if (row == MID_ROW) centre_q <= load_value;
			end
			BASE_2: node_q <= curr_q;
			CALC: begin
				top_q <= curr_q;
				prev_node_q <= prev_q;
			end
			UPDATE: begin
				// Shift the window up one row
				node_q <= top_q;
				bottom_q <= node_q;
				if (row == MID_ROW) centre_q <= next_node;
			end
			default: ;
		endcase
	end

	assign curr_node = node_q;
	assign centre = centre_q;
	assign done = (state == IDLE);

endmodule

`default_nettype wire

/* design/profile_loader.sv */
`default_nettype none

module profile_loader #(
	parameter int NUM_COLUMNS = 7
) (
	input  logic                    clk,
	input  logic                    reset,
	input  drum_pkg::drum_config_t  cfg,
	output drum_pkg::column_seed_t  seeds [NUM_COLUMNS],
	output logic                    start
);

	localparam int CW = $clog2(NUM_COLUMNS);
	localparam logic [CW-1:0] LAST_COL = CW'(NUM_COLUMNS - 1);
	localparam logic [CW-1:0] MID_COL  = CW'(NUM_COLUMNS / 2);

	localparam logic [1:0] LOADING = 2'd0;
	localparam logic [1:0] KICK    = 2'd1;
	localparam logic [1:0] RUNNING = 2'd2;

	logic [1:0]      state;
	logic [CW-1:0]   col;
	drum_pkg::node_t run_center;
	drum_pkg::node_t run_incr;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LOADING;
			col <= '0;
			run_center <= cfg.init_node;
			run_incr <= cfg.incr_col;
		end else begin
			case (state)
				LOADING: begin
					col <= col + 1'b1;
					// Climb to the middle column, then descend
					if (col < MID_COL) begin
						run_center <= run_center + cfg.incr_row;
						run_incr <= run_incr + cfg.incr_col;
					end else begin
						run_center <= run_center - cfg.incr_row;
						run_incr <= run_incr - cfg.incr_col;
					end
					if (col == LAST_COL) state <= KICK;
				end
				KICK: state <= RUNNING;
				default: ;
			endcase
		end
	end

	// Seeds hold once loading is over
	always_ff @(posedge clk) begin
		if (state == LOADING) begin
			seeds[col] <= '{init_center: run_center, incr: run_incr};
		end
	end

	assign start = (state == KICK);

endmodule

`default_nettype wire

/* design/center_tap.sv */
`default_nettype none

module center_tap #(
	parameter int NUM_COLUMNS   = 7,
	parameter int TENSION_SHIFT = 5,
	parameter int CREDIT_INIT   = 4
) (
	input  logic                    clk,
	input  logic                    reset,
	input  drum_pkg::node_t         centre,
	input  drum_pkg::node_t         init_rho,
	input  logic [NUM_COLUMNS-1:0]  done,
	input  logic                    credit_return,
	output logic                    step,
	output drum_pkg::node_t         rho,
	output logic                    sample_valid,
	output drum_pkg::sample_t       sample_data
);

	localparam int CW = $clog2(CREDIT_INIT + 1) + 1;

	logic [CW-1:0]   credits;
	logic            fire;
	drum_pkg::node_t scaled, rho_sum;

	////////////////////
	// Nonlinear tension
	////////////////////
	assign scaled = centre >>> TENSION_SHIFT;
	assign rho_sum = init_rho + drum_pkg::fix_mul(scaled, scaled);
	assign rho = (rho_sum > drum_pkg::RHO_MAX) ? drum_pkg::RHO_MAX : rho_sum;

	// Grid idle and the sink has room
	assign fire = (&done) && (credits != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= CW'(CREDIT_INIT);
		end else begin
			credits <= credits + CW'(credit_return) - CW'(fire);
		end
	end

	assign step = fire;
	assign sample_valid = fire;
	// Sign extend the node and place it in the upper sample bits
	assign sample_data = {{(32 - 18){centre[17]}}, centre} << drum_pkg::SAMPLE_SHIFT;

endmodule

`default_nettype wire

/* design/drum_top.sv */
`default_nettype none

module drum_top #(
	parameter int NUM_COLUMNS   = 7,
	parameter int NUM_ROWS      = 7,
	parameter int ETA_SHIFT     = 9,
	parameter int TENSION_SHIFT = 5,
	parameter int CREDIT_INIT   = 4
) (
	input  logic                    clk,
	input  logic                    reset,
	input  drum_pkg::drum_config_t  cfg,
	input  logic                    credit_return,
	output logic                    sample_valid,
	output drum_pkg::sample_t       sample_data
);

	drum_pkg::column_seed_t seeds [NUM_COLUMNS];
	drum_pkg::node_t        col_node [NUM_COLUMNS];
	drum_pkg::node_t        col_centre [NUM_COLUMNS];
	logic [NUM_COLUMNS-1:0] done;
	logic                   start;
	logic                   step;
	drum_pkg::node_t        rho;

	profile_loader #(.NUM_COLUMNS(NUM_COLUMNS)) u_loader (
		.clk   (clk),
		.reset (reset),
		.cfg   (cfg),
		.seeds (seeds),
		.start (start)
	);

	center_tap #(
		.NUM_COLUMNS   (NUM_COLUMNS),
		.TENSION_SHIFT (TENSION_SHIFT),
		.CREDIT_INIT   (CREDIT_INIT)
	) u_center_tap (
		.clk           (clk),
		.reset         (reset),
		.centre        (col_centre[NUM_COLUMNS / 2]),
		.init_rho      (cfg.init_rho),
		.done          (done),
		.credit_return (credit_return),
		.step          (step),
		.rho           (rho),
		.sample_valid  (sample_valid),
		.sample_data   (sample_data)
	);

	for (genvar c = 0; c < NUM_COLUMNS; c++) begin : g_col
		drum_pkg::node_t left_in;
		drum_pkg::node_t right_in;

		// Outer columns are pinned to the rim
		if (c == 0) begin : g_left_rim
			assign left_in = '0;
		end else begin : g_left
			assign left_in = col_node[c - 1];
		end
		if (c == NUM_COLUMNS - 1) begin : g_right_rim
			assign right_in = '0;
		end else begin : g_right
			assign right_in = col_node[c + 1];
		end

		drum_column #(.NUM_ROWS(NUM_ROWS), .ETA_SHIFT(ETA_SHIFT)) u_column (
			.clk        (clk),
			.reset      (reset),
			.start      (start),
			.step       (step),
			.seed       (seeds[c]),
			.init_node  (cfg.init_node),
			.rho        (rho),
			.left_node  (left_in),
			.right_node (right_in),
			.curr_node  (col_node[c]),
			.centre     (col_centre[c]),
			.done       (done[c])
		);
	end

endmodule

`default_nettype wire

/* verification/drum_props.sv */
`default_nettype none

module drum_props #(
	parameter int NUM_COLUMNS = 7,
	parameter int CW          = 4
) (
	input logic                   clk,
	input logic                   reset,
	input logic [NUM_COLUMNS-1:0] done,
	input logic                   step,
	input logic                   sample_valid,
	input logic [CW-1:0]          credits
);

	timeunit 1ns;
	timeprecision 1ps;

	// Every step carries exactly one sample
	step_with_sample: assert property (@(posedge clk) disable iff (reset)
		step == sample_valid) else $error("step and sample_valid differ");

	step_when_idle: assert property (@(posedge clk) disable iff (reset)
		step |-> &done) else $error("step issued while a column was busy");

	// Guard bit catches an underflow of the counter
	credit_no_wrap: assert property (@(posedge clk) disable iff (reset)
		!credits[CW-1]) else $error("credit counter wrapped below zero");

endmodule

bind center_tap drum_props #(.NUM_COLUMNS(NUM_COLUMNS), .CW(CW)) u_props (
	.clk          (clk),
	.reset        (reset),
	.done         (done),
	.step         (step),
	.sample_valid (sample_valid),
	.credits      (credits)
);

`default_nettype wire

/* verification/drum_tb.sv */
`default_nettype none

module drum_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_COLUMNS   = 7;
	localparam int NUM_ROWS      = 7;
	localparam int ETA_SHIFT     = 9;
	localparam int TENSION_SHIFT = 5;
	localparam int CREDIT_INIT   = 4;

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 10;
	localparam int LOAD_CYCLES  = NUM_COLUMNS + NUM_ROWS + 2;
	localparam int QUIET_CYCLES = 4 * (2 * NUM_ROWS + 4);
	localparam int NUM_TESTS    = 4;

	typedef struct packed {
		drum_pkg::drum_config_t cfg;
		logic [15:0]            num_samples;
		logic [7:0]             max_delay;
	} test_row_t;

	// init_node, incr_col, incr_row, init_rho, then sample count and longest credit delay
	localparam test_row_t TESTS [NUM_TESTS] = '{
		'{'{18'sh00000, 18'sh00000, 18'sh00000, 18'sh00000}, 16'd10, 8'd3},
		'{'{18'sh00400, 18'sh00200, 18'sh01000, 18'sh04000}, 16'd24, 8'd6},
		'{'{-18'sh00200, -18'sh00200, -18'sh00C00, 18'sh06000}, 16'd16, 8'd0},
		'{'{18'sh00800, 18'sh00400, 18'sh00800, 18'sh02000}, 16'(CREDIT_INIT), 8'd2}
	};

	logic                   clk;
	logic                   reset;
	drum_pkg::drum_config_t cfg;
	logic                   credit_return;
	logic                   sample_valid;
	drum_pkg::sample_t      sample_data;

	int value_errors = 0;
	int count_errors = 0;
	int timing_errors = 0;
	int cycle_count = 0;
	int timeout_limit = 0;

	drum_top #(
		.NUM_COLUMNS   (NUM_COLUMNS),
		.NUM_ROWS      (NUM_ROWS),
		.ETA_SHIFT     (ETA_SHIFT),
		.TENSION_SHIFT (TENSION_SHIFT),
		.CREDIT_INIT   (CREDIT_INIT)
	) i_drum_top (
		.clk           (clk),
		.reset         (reset),
		.cfg           (cfg),
		.credit_return (credit_return),
		.sample_valid  (sample_valid),
		.sample_data   (sample_data)
	);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	////////////////////
	// Reference model
	////////////////////

	// Middle node after loading: column peak capped against the row ramp
	function automatic int expected_centre(input drum_pkg::drum_config_t c);
		int peak;
		int ramp;
		peak = int'($signed(c.init_node)) + (NUM_COLUMNS / 2) * int'($signed(c.incr_row));
		// Middle column climbs by (its index + 1) times incr_col per row
		ramp = int'($signed(c.init_node))
			+ (NUM_ROWS / 2) * (NUM_COLUMNS / 2 + 1) * int'($signed(c.incr_col));
		return (ramp < peak) ? ramp : peak;
	endfunction

	function automatic int magnitude(input int v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic int cycle_budget();
		int total;
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total += 1 + RESET_CYCLES + LOAD_CYCLES + QUIET_CYCLES;
			total += int'(TESTS[t].num_samples) * (2 * NUM_ROWS + 4 + int'(TESTS[t].max_delay));
		end
		return total + 100;
	endfunction

	task automatic check_sample(input drum_pkg::drum_config_t c, input int index,
			input int since_reset, input drum_pkg::sample_t data);
		int first_centre;
		int centre;
		drum_pkg::sample_t expected;
		first_centre = expected_centre(c);
		centre = int'(drum_pkg::node_t'(data >> drum_pkg::SAMPLE_SHIFT));
		expected = drum_pkg::sample_t'(first_centre <<< drum_pkg::SAMPLE_SHIFT);
		assert (since_reset > LOAD_CYCLES) else begin
			timing_errors++;
			$display("Sample %0d came %0d cycles after reset, before loading ended",
				index, since_reset);
		end
		assert ((data & ((32'd1 << drum_pkg::SAMPLE_SHIFT) - 32'd1)) == 32'd0) else begin
			value_errors++;
			$display("ERR sample_data: low bits set in 0x%08h", data);
		end
		if (index == 0) begin
			assert (data == expected) else begin
				value_errors++;
				$display("ERR sample_data: got 0x%08h, expected 0x%08h", data, expected);
			end
		end
		if (c == '0) begin
			assert (data == 32'd0) else begin
				value_errors++;
				$display("ERR sample_data: got 0x%08h, expected 0x00000000", data);
			end
		end else begin
			// Damped drum never swings far past its starting peak
			assert (magnitude(centre) <= 4 * magnitude(first_centre)) else begin
				value_errors++;
				$display("ERR sample_data: 0x%08h beyond bound 0x%05h", data,
					4 * magnitude(first_centre));
			end
		end
	endtask

	task automatic run_test(input int index, input test_row_t tr);
		int target;
		int received;
		int returned;
		int wait_left;
		int since_reset;
		int quiet;
		target = int'(tr.num_samples) - CREDIT_INIT;
		received = 0;
		returned = 0;
		since_reset = 0;
		quiet = 0;
		wait_left = int'($urandom_range(32'(tr.max_delay), 32'd0));
		@(posedge clk);
		reset <= 1'b1;
		cfg <= tr.cfg;
		credit_return <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		while (quiet < QUIET_CYCLES) begin
			@(posedge clk);
			since_reset++;
			credit_return <= 1'b0;
			if (sample_valid) begin
				check_sample(tr.cfg, received, since_reset, sample_data);
				received++;
				// Silence is measured from the latest sample
				quiet = 0;
			end
			// Sink hands back one credit per consumed sample, after a random delay
			if (returned == target) begin
				quiet++;
			end else if (received > returned) begin
				if (wait_left == 0) begin
					credit_return <= 1'b1;
					returned++;
					wait_left = int'($urandom_range(32'(tr.max_delay), 32'd0));
				end else begin
					wait_left--;
				end
			end
		end
		assert (received == int'(tr.num_samples)) else begin
			count_errors++;
			$display("ERR sample_count: got 0x%0h, expected 0x%0h", received,
				int'(tr.num_samples));
		end
		$display("Row %0d: %0d samples, %0d credits returned", index, received, returned);
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped issuing samples", cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hb359));
		reset = 1'b1;
		cfg = '0;
		credit_return = 1'b0;
		timeout_limit = cycle_budget();
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t, TESTS[t]);
		end
		$display("Errors: value %0d, count %0d, timing %0d", value_errors, count_errors,
			timing_errors);
		if (value_errors + count_errors + timing_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
design/drum_pkg.sv
design/column_memory.sv
design/node_update.sv
design/drum_column.sv
design/profile_loader.sv
design/center_tap.sv
design/drum_top.sv
verification/drum_props.sv
verification/drum_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the drum testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module drum_tb \
	-Mdir obj_dir -o drum_sim -f sources.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/drum_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
